//--- verilog/poly_pkg.sv
package poly_pkg;

	////////////////////
	// polynomial shape

	localparam int POLY_LEN    = 251;   // bits per polynomial
	localparam int INDEX_W     = 8;     // bit position width
	localparam int POLY_WEIGHT = 5;     // set bits per polynomial
	localparam int NUM_POLY    = 2;     // h0 and h1
	localparam int POLY_SEL_W  = 1;     // polynomial number width

	////////////////////
	// random word layout

	localparam int RNG_W       = 32;
	localparam int FIELD_B_LSB = 16;    // field a starts at bit 0

	////////////////////
	// dense stream

	localparam int DENSE_W      = 16;   // bits per dense word
	localparam int DENSE_WORDS  = 16;   // 256 bits, covers POLY_LEN
	localparam int DENSE_ADDR_W = 4;

endpackage

//--- verilog/keygen_ctrl_pkg.sv
package keygen_ctrl_pkg;

	// generation phases
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,   // waiting for first start
		ST_SAMPLE = 2'd1,   // filling h0 then h1
		ST_EXPAND = 2'd2,   // streaming dense words
		ST_DONE   = 2'd3    // finished, new start allowed
	} keygen_state_t;

endpackage

//--- verilog/keygen_ctrl.sv
`timescale 1ns/10ps

module keygen_ctrl (
	input  logic                          clk,
	input  logic                          rst_b,
	input  logic                          start,
	input  logic [poly_pkg::NUM_POLY-1:0] full_vec,
	input  logic                          expand_done,
	output logic                          clear,
	output logic                          sampling,
	output logic                          expand_start,
	output logic                          busy,
	output logic                          done
);

	keygen_ctrl_pkg::keygen_state_t state;

	assign sampling = (state == keygen_ctrl_pkg::ST_SAMPLE);
	assign busy     = (state == keygen_ctrl_pkg::ST_SAMPLE) ||
	                  (state == keygen_ctrl_pkg::ST_EXPAND);

	////////////////////
	// phase sequencing

	always_ff @(posedge clk) begin
		if (!rst_b) begin
			state        <= keygen_ctrl_pkg::ST_IDLE;
			clear        <= 1'b0;
			expand_start <= 1'b0;
			done         <= 1'b0;
		end else begin
			clear        <= 1'b0;   // strobes default low
			expand_start <= 1'b0;
			done         <= 1'b0;
			case (state)
				keygen_ctrl_pkg::ST_IDLE: begin
					if (start) begin
						state <= keygen_ctrl_pkg::ST_SAMPLE;
						clear <= 1'b1;   // wipe position lists
					end
				end
				keygen_ctrl_pkg::ST_SAMPLE: begin
					// full_vec already counts the word in flight
					if (&full_vec) begin
						state        <= keygen_ctrl_pkg::ST_EXPAND;
						expand_start <= 1'b1;
					end
				end
				keygen_ctrl_pkg::ST_EXPAND: begin
					if (expand_done) begin
						state <= keygen_ctrl_pkg::ST_DONE;
						done  <= 1'b1;
					end
				end
				keygen_ctrl_pkg::ST_DONE: begin
					if (start) begin
						state <= keygen_ctrl_pkg::ST_SAMPLE;
						clear <= 1'b1;   // drop previous key
					end
				end
				default: state <= keygen_ctrl_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

//--- verilog/index_sampler.sv
`timescale 1ns/10ps

module index_sampler (
	input  logic                          clk,
	input  logic                          rst_b,
	input  logic                          sampling,
	input  logic                          rng_valid,
	input  logic [poly_pkg::RNG_W-1:0]    rng_in,
	input  logic [poly_pkg::NUM_POLY-1:0] full_vec,
	output logic [poly_pkg::INDEX_W-1:0]  cand_a,
	output logic [poly_pkg::INDEX_W-1:0]  cand_b,
	output logic [poly_pkg::NUM_POLY-1:0] cand_a_valid,
	output logic [poly_pkg::NUM_POLY-1:0] cand_b_valid
);

	logic [poly_pkg::INDEX_W-1:0]  field_a;
	logic [poly_pkg::INDEX_W-1:0]  field_b;
	logic                          a_in_range;
	logic                          b_in_range;
	logic                          take;
	logic [poly_pkg::NUM_POLY-1:0] target;   // one-hot, zero if all full

	assign field_a = rng_in[poly_pkg::INDEX_W-1:0];
	assign field_b = rng_in[poly_pkg::FIELD_B_LSB +: poly_pkg::INDEX_W];

	// rejection against the polynomial length
	assign a_in_range = (int'(field_a) < poly_pkg::POLY_LEN);
	assign b_in_range = (int'(field_b) < poly_pkg::POLY_LEN);

	assign take = sampling && rng_valid;

	// lowest generator that is not full; full_vec includes the word just
	// sent, so a generator filled by it is already skipped here
	always_comb begin
		target = '0;
		for (int g = poly_pkg::NUM_POLY - 1; g >= 0; g--) begin
			if (!full_vec[g]) begin
				target    = '0;
				target[g] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_b) begin
			cand_a_valid <= '0;
			cand_b_valid <= '0;
		end else begin
			cand_a_valid <= (take && a_in_range) ? target : '0;
			cand_b_valid <= (take && b_in_range) ? target : '0;   // same target as a
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			cand_a <= field_a;
			cand_b <= field_b;
		end
	end

endmodule

//--- verilog/sparse_poly_gen.sv
`timescale 1ns/10ps

module sparse_poly_gen (
	input  logic                                             clk,
	input  logic                                             rst_b,
	input  logic                                             clear,
	input  logic [poly_pkg::INDEX_W-1:0]                     cand_a,
	input  logic [poly_pkg::INDEX_W-1:0]                     cand_b,
	input  logic                                             cand_a_valid,
	input  logic                                             cand_b_valid,
	output logic [poly_pkg::POLY_WEIGHT*poly_pkg::INDEX_W-1:0] positions,
	output logic                                             full
);

	typedef logic [$clog2(poly_pkg::POLY_WEIGHT + 1) - 1:0] cnt_t;

	logic [poly_pkg::INDEX_W-1:0] pos_q [poly_pkg::POLY_WEIGHT];
	cnt_t                         count;
	cnt_t                         count_next;
	logic                         dup_a;
	logic                         dup_b;
	logic                         store_a;
	logic                         store_b;

	////////////////////
	// duplicate check and slot use

	always_comb begin
		dup_a = 1'b0;
		dup_b = 1'b0;
		for (int k = 0; k < poly_pkg::POLY_WEIGHT; k++) begin
			if (k < int'(count) && pos_q[k] == cand_a) begin
				dup_a = 1'b1;
			end
			if (k < int'(count) && pos_q[k] == cand_b) begin
				dup_b = 1'b1;
			end
		end
		store_a = cand_a_valid && !dup_a && (int'(count) < poly_pkg::POLY_WEIGHT);
		// b loses to an equal a and needs its own free slot
		store_b = cand_b_valid && !dup_b && !(store_a && cand_b == cand_a) &&
		          (int'(count + cnt_t'(store_a)) < poly_pkg::POLY_WEIGHT);
		count_next = clear ? '0 : count + cnt_t'(store_a) + cnt_t'(store_b);
	end

	// looks one edge ahead so the sampler moves on right away
	assign full = (count_next == cnt_t'(poly_pkg::POLY_WEIGHT));

	always_ff @(posedge clk) begin
		if (!rst_b) begin
			count <= '0;
		end else begin
			count <= count_next;
		end
	end

	always_ff @(posedge clk) begin
		if (clear) begin
			for (int k = 0; k < poly_pkg::POLY_WEIGHT; k++) begin
				pos_q[k] <= '0;
			end
		end else begin
			if (store_a) begin
				pos_q[count] <= cand_a;
			end
			if (store_b) begin
				pos_q[count + cnt_t'(store_a)] <= cand_b;   // slot after a
			end
		end
	end

	always_comb begin
		for (int k = 0; k < poly_pkg::POLY_WEIGHT; k++) begin
			positions[k*poly_pkg::INDEX_W +: poly_pkg::INDEX_W] = pos_q[k];
		end
	end

endmodule

//--- verilog/dense_expander.sv
`timescale 1ns/10ps

module dense_expander (
	input  logic clk,
	input  logic rst_b,
	input  logic expand_start,
	input  logic [poly_pkg::NUM_POLY*poly_pkg::POLY_WEIGHT*poly_pkg::INDEX_W-1:0] positions_all,
	output logic                              dense_valid,
	output logic [poly_pkg::POLY_SEL_W-1:0]   dense_poly,
	output logic [poly_pkg::DENSE_ADDR_W-1:0] dense_addr,
	output logic [poly_pkg::DENSE_W-1:0]      dense_data,
	output logic                              expand_done
);

	typedef logic [poly_pkg::INDEX_W-1:0]      index_t;
	typedef logic [poly_pkg::POLY_SEL_W-1:0]   poly_t;
	typedef logic [poly_pkg::DENSE_ADDR_W-1:0] addr_t;

	localparam poly_t LAST_POLY = poly_t'(poly_pkg::NUM_POLY - 1);
	localparam addr_t LAST_ADDR = addr_t'(poly_pkg::DENSE_WORDS - 1);

	logic                         running;
	logic                         emit;
	logic                         last_word;
	poly_t                        poly_cnt;
	addr_t                        addr_cnt;
	index_t                       base;
	logic [poly_pkg::DENSE_W-1:0] word;

	assign emit      = expand_start || running;
	assign last_word = (poly_cnt == LAST_POLY) && (addr_cnt == LAST_ADDR);
	assign base      = index_t'(int'(addr_cnt) * poly_pkg::DENSE_W);   // first bit of word

	////////////////////
	// sparse to dense

	always_comb begin
		word = '0;
		for (int j = 0; j < poly_pkg::DENSE_W; j++) begin
			for (int k = 0; k < poly_pkg::POLY_WEIGHT; k++) begin
				if (positions_all[(int'(poly_cnt) * poly_pkg::POLY_WEIGHT + k) *
				                  poly_pkg::INDEX_W +: poly_pkg::INDEX_W] ==
				    base + index_t'(j)) begin
					word[j] = 1'b1;
				end
			end
		end
	end

	////////////////////
	// word walk

	always_ff @(posedge clk) begin
		if (!rst_b) begin
			running     <= 1'b0;
			poly_cnt    <= '0;
			addr_cnt    <= '0;
			dense_valid <= 1'b0;
			expand_done <= 1'b0;
		end else begin
			dense_valid <= emit;
			// one cycle behind the last strobe
			expand_done <= dense_valid && (dense_poly == LAST_POLY) &&
			               (dense_addr == LAST_ADDR);
			if (emit) begin
				running <= !last_word;
				if (addr_cnt == LAST_ADDR) begin
					addr_cnt <= '0;
					poly_cnt <= last_word ? '0 : poly_cnt + poly_t'(1);   // next polynomial
				end else begin
					addr_cnt <= addr_cnt + addr_t'(1);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			dense_data <= word;
			dense_poly <= poly_cnt;
			dense_addr <= addr_cnt;
		end
	end

endmodule

//--- verilog/bike_keygen_top.sv
`timescale 1ns/10ps

module bike_keygen_top (
	input  logic                              clk,
	input  logic                              rst_b,
	input  logic                              start,
	input  logic                              rng_valid,
	input  logic [poly_pkg::RNG_W-1:0]        rng_in,
	output logic                              busy,
	output logic                              done,
	output logic                              dense_valid,
	output logic [poly_pkg::POLY_SEL_W-1:0]   dense_poly,
	output logic [poly_pkg::DENSE_ADDR_W-1:0] dense_addr,
	output logic [poly_pkg::DENSE_W-1:0]      dense_data
);

	logic                          clear;
	logic                          sampling;
	logic                          expand_start;
	logic                          expand_done;
	logic [poly_pkg::NUM_POLY-1:0] full_vec;
	logic [poly_pkg::INDEX_W-1:0]  cand_a;
	logic [poly_pkg::INDEX_W-1:0]  cand_b;
	logic [poly_pkg::NUM_POLY-1:0] cand_a_valid;
	logic [poly_pkg::NUM_POLY-1:0] cand_b_valid;
	logic [poly_pkg::NUM_POLY*poly_pkg::POLY_WEIGHT*poly_pkg::INDEX_W-1:0] positions_all;

	keygen_ctrl keygen_ctrl_inst (
		.clk          (clk),
		.rst_b        (rst_b),
		.start        (start),
		.full_vec     (full_vec),
		.expand_done  (expand_done),
		.clear        (clear),
		.sampling     (sampling),
		.expand_start (expand_start),
		.busy         (busy),
		.done         (done)
	);

	index_sampler index_sampler_inst (
		.clk          (clk),
		.rst_b        (rst_b),
		.sampling     (sampling),
		.rng_valid    (rng_valid),
		.rng_in       (rng_in),
		.full_vec     (full_vec),
		.cand_a       (cand_a),
		.cand_b       (cand_b),
		.cand_a_valid (cand_a_valid),
		.cand_b_valid (cand_b_valid)
	);

	// h0 is generator 0, h1 is generator 1
	for (genvar g = 0; g < poly_pkg::NUM_POLY; g++) begin : gen_poly
		sparse_poly_gen sparse_poly_gen_inst (
			.clk          (clk),
			.rst_b        (rst_b),
			.clear        (clear),
			.cand_a       (cand_a),
			.cand_b       (cand_b),
			.cand_a_valid (cand_a_valid[g]),
			.cand_b_valid (cand_b_valid[g]),
			.positions    (positions_all[g*poly_pkg::POLY_WEIGHT*poly_pkg::INDEX_W +:
			                             poly_pkg::POLY_WEIGHT*poly_pkg::INDEX_W]),
			.full         (full_vec[g])
		);
	end

	dense_expander dense_expander_inst (
		.clk           (clk),
		.rst_b         (rst_b),
		.expand_start  (expand_start),
		.positions_all (positions_all),
		.dense_valid   (dense_valid),
		.dense_poly    (dense_poly),
		.dense_addr    (dense_addr),
		.dense_data    (dense_data),
		.expand_done   (expand_done)
	);

endmodule

//--- verification/bike_keygen_tb.sv
`timescale 1ns/10ps

module bike_keygen_tb;

	localparam int          CLK_PERIOD  = 20;
	localparam int          DRIVE_DELAY = 2;
	localparam logic [15:0] LFSR_SEED   = 16'd17;
	localparam string       DATA_FILE   = "verification/bike_keygen_testdata.txt";
	localparam int          NUM_RUNS    = 2;
	localparam int          MAX_WORDS   = 16;
	localparam int          EXP_POS     = 10;   // h0 then h1
	localparam int          MEM_DEPTH   = 64;
	localparam int          TOTAL_WORDS = 32;   // dense words per run

	logic        clk;
	logic        rst_b;
	logic        start;
	logic        rng_valid;
	logic [31:0] rng_in;
	logic        busy;
	logic        done;
	logic        dense_valid;
	logic [0:0]  dense_poly;
	logic [3:0]  dense_addr;
	logic [15:0] dense_data;

	logic [31:0] test_mem [MEM_DEPTH];
	int          run_count [NUM_RUNS];
	logic [31:0] run_words [NUM_RUNS][MAX_WORDS];
	logic [7:0]  run_pos [NUM_RUNS][EXP_POS];
	logic [15:0] lfsr_state;
	int          watchdog_cycles;
	bit          data_loaded;

	bike_keygen_top bike_keygen_top_inst (
		.clk         (clk),
		.rst_b       (rst_b),
		.start       (start),
		.rng_valid   (rng_valid),
		.rng_in      (rng_in),
		.busy        (busy),
		.done        (done),
		.dense_valid (dense_valid),
		.dense_poly  (dense_poly),
		.dense_addr  (dense_addr),
		.dense_data  (dense_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////
	// helpers

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);   // galois taps
	endfunction

	task automatic random_gap(output int gap);
		gap = 0;
		for (int b = 0; b < 2; b++) begin
			gap = gap * 2 + int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);   // one step per bit
		end
	endtask

	// bit j of word addr is set when addr*16+j is a listed position
	function automatic logic [15:0] expected_dense(input int run, input int poly, input int addr);
		logic [15:0] w;
		w = '0;
		for (int j = 0; j < 16; j++) begin
			for (int k = 0; k < 5; k++) begin
				if (int'(run_pos[run][poly * 5 + k]) == addr * 16 + j) begin
					w[j] = 1'b1;
				end
			end
		end
		return w;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic tick();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic load_data();
		int p;
		$readmemh(DATA_FILE, test_mem);
		p = 0;
		watchdog_cycles = 3 + 6;   // reset and idle phase
		for (int r = 0; r < NUM_RUNS; r++) begin
			run_count[r] = int'(test_mem[p]);
			p++;
			assert (run_count[r] > 0 && run_count[r] <= MAX_WORDS) else begin
				$display("test data file holds a bad word count for run %0d", r + 1);
				$display("Simulation failed");
				$fatal(1, "bad test data");
			end
			for (int i = 0; i < run_count[r]; i++) begin
				run_words[r][i] = test_mem[p];
				p++;
			end
			for (int k = 0; k < EXP_POS; k++) begin
				run_pos[r][k] = test_mem[p][7:0];
				p++;
			end
			watchdog_cycles += 4 * run_count[r] + TOTAL_WORDS + 40;
		end
		data_loaded = 1'b1;
	endtask

	////////////////////
	// run phases

	task automatic send_words(input int run);
		int gap;
		for (int i = 0; i < run_count[run]; i++) begin
			random_gap(gap);
			repeat (gap) tick();
			rng_valid = 1'b1;
			rng_in    = run_words[run][i];
			tick();
			rng_valid = 1'b0;
			rng_in    = '0;
		end
	endtask

	task automatic collect_dense(input int run);
		for (int n = 0; n < TOTAL_WORDS; n++) begin
			if (n == 0) begin
				while (!dense_valid) tick();   // end of sampling varies
			end else begin
				tick();
				check_value("dense_valid", 32'(dense_valid), 32'd1);
			end
			check_value("dense_poly", 32'(dense_poly), 32'(n / 16));
			check_value("dense_addr", 32'(dense_addr), 32'(n % 16));
			check_value("dense_data", 32'(dense_data), 32'(expected_dense(run, n / 16, n % 16)));
		end
		tick();
		check_value("dense_valid", 32'(dense_valid), 32'd0);
		check_value("done", 32'(done), 32'd0);
		tick();   // done two cycles after last word
		check_value("done", 32'(done), 32'd1);
		check_value("busy", 32'(busy), 32'd0);
		check_value("state", 32'(bike_keygen_top_inst.keygen_ctrl_inst.state),
		            32'(keygen_ctrl_pkg::ST_DONE));
		tick();
		check_value("done", 32'(done), 32'd0);
	endtask

	task automatic do_run(input int run);
		start = 1'b1;
		tick();
		start = 1'b0;
		check_value("busy", 32'(busy), 32'd1);
		fork
			send_words(run);
			collect_dense(run);
		join
	endtask

	initial begin
		rst_b       = 1'b0;
		start       = 1'b0;
		rng_valid   = 1'b0;
		rng_in      = '0;
		lfsr_state  = LFSR_SEED;
		data_loaded = 1'b0;
		load_data();
		repeat (3) tick();
		rst_b = 1'b1;

		// words before any start must be ignored
		for (int i = 0; i < 6; i++) begin
			rng_valid = 1'b1;
			rng_in    = run_words[0][i % run_count[0]];
			tick();
			check_value("busy", 32'(busy), 32'd0);
			check_value("dense_valid", 32'(dense_valid), 32'd0);
			check_value("done", 32'(done), 32'd0);
			check_value("state", 32'(bike_keygen_top_inst.keygen_ctrl_inst.state),
			            32'(keygen_ctrl_pkg::ST_IDLE));
			check_value("full_vec", 32'(bike_keygen_top_inst.full_vec), 32'd0);
		end
		rng_valid = 1'b0;
		rng_in    = '0;

		for (int r = 0; r < NUM_RUNS; r++) begin
			do_run(r);
		end

		$display("Simulation passed");
		$finish;
	end

	////////////////////
	// watchdog

	initial begin
		wait (data_loaded);
		repeat (watchdog_cycles) @(posedge clk);
		$display("generation did not finish in time");
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- bike_keygen.f
verilog/poly_pkg.sv
verilog/keygen_ctrl_pkg.sv
verilog/keygen_ctrl.sv
verilog/index_sampler.sv
verilog/sparse_poly_gen.sv
verilog/dense_expander.sv
verilog/bike_keygen_top.sv
verification/bike_keygen_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module bike_keygen_tb \
	-f bike_keygen.f -o bike_keygen_sim

./obj_dir/bike_keygen_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
grep -q "Simulation passed" sim.log

//--- verification/bike_keygen_testdata.txt
// per run: word count, the random words, then ten positions in hex
// (five for h0, then five for h1); field a is bits 7:0, field b bits 23:16
// run 1
9
7AFC3C0A
00200E0A
C355A155
1203FFFB
006400C8
99FA2201
0010000F
00FE11FF
5507EE80
0A 20 55 03 C8
01 FA 0F 10 80
// run 2
6
00110005
006300F0
00FD0040
00F90000
0021001F
AB4DCD4D
05 11 F0 63 40
00 F9 1F 21 4D
